//--- vec_pkg.sv
/* Shared definitions of the vector unit: element and register widths, opcodes and the
   request and response structs. Both the RTL and the testbench refer to them by scoped names. */
package vec_pkg;

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  typedef logic [ElemWidth-1:0]       elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Codes 9 to 15 are illegal
  typedef enum logic [3:0] {
    VADD    = 4'd0,
    VSUB    = 4'd1,
    VAND    = 4'd2,
    VOR     = 4'd3,
    VXOR    = 4'd4,
    VMV_V_X = 4'd5,  // splat scalar into vd
    VID     = 4'd6,  // element index into vd
    VMV_X_S = 4'd7,  // element 0 of vs2 to scalar
    VREDSUM = 4'd8   // sum of vs2 to scalar
  } vec_op_e;

  // Request from the scalar core
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_acc_req_t;

  // Response to the scalar core
  typedef struct packed {
    elem_t result;
    logic  error;
  } vec_acc_resp_t;

  // Instruction broadcast to the lanes, legal opcodes only
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vec_pe_req_t;

  // Reply of one lane
  typedef struct packed {
    logic  done;
    elem_t partial;
  } vec_lane_resp_t;

  // Width of a slot index inside a lane, at least one bit
  function automatic int unsigned slot_width(int unsigned elems);
    return (elems > 1) ? $clog2(elems) : 1;
  endfunction

endpackage

//--- vec_lane_vrf.sv
/* Slice of the vector register file held by one lane. Two combinational
   read ports share a slot index; the single write port is synchronous. */
`timescale 1ns/1ns

module vec_lane_vrf #(
  parameter  int unsigned ElemsPerLane = 2,
  localparam int unsigned SlotW        = vec_pkg::slot_width(ElemsPerLane)
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Read ports
  input  vec_pkg::vreg_idx_t rd_a_reg_i,
  input  vec_pkg::vreg_idx_t rd_b_reg_i,
  input  logic [SlotW-1:0]   rd_slot_i,
  output vec_pkg::elem_t     rd_a_data_o,
  output vec_pkg::elem_t     rd_b_data_o,
  // Write port
  input  logic               wr_en_i,
  input  vec_pkg::vreg_idx_t wr_reg_i,
  input  logic [SlotW-1:0]   wr_slot_i,
  input  vec_pkg::elem_t     wr_data_i
);

  // Register r, slot s holds element s * NrLanes + lane id
  vec_pkg::elem_t vreg_q [vec_pkg::NrVRegs][ElemsPerLane];

  assign rd_a_data_o = vreg_q[rd_a_reg_i][rd_slot_i];
  assign rd_b_data_o = vreg_q[rd_b_reg_i][rd_slot_i];

  // Registers read as zero until written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
        for (int s = 0; s < ElemsPerLane; s++) begin
          vreg_q[r][s] <= '0;
        end
      end
    end else if (wr_en_i) begin
      vreg_q[wr_reg_i][wr_slot_i] <= wr_data_i;
    end
  end

endmodule

//--- vec_lane.sv
/* One vector lane. Walks its element slots one per cycle after each broadcast,
   runs the integer ALU and builds the partial scalar for reductions and moves. */
`timescale 1ns/1ns

module vec_lane #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned ElemsPerLane = 2,
  parameter int unsigned LaneId       = 0
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Sequencer
  input  vec_pkg::vec_pe_req_t    pe_req_i,
  input  logic                    pe_req_valid_i,
  output vec_pkg::vec_lane_resp_t lane_resp_o
);

  localparam int unsigned      SlotW    = vec_pkg::slot_width(ElemsPerLane);
  localparam logic [SlotW-1:0] LastSlot = SlotW'(ElemsPerLane - 1);

  vec_pkg::vec_pe_req_t req_q;
  logic                 busy_q;
  logic                 done_q;
  logic [SlotW-1:0]     slot_q;
  vec_pkg::elem_t       a_data;
  vec_pkg::elem_t       b_data;
  vec_pkg::elem_t       alu_res;
  vec_pkg::elem_t       elem_idx;
  vec_pkg::elem_t       partial_q;
  logic                 wr_en;

  // vs1 on port A, vs2 on port B
  vec_lane_vrf #(
    .ElemsPerLane (ElemsPerLane)
  ) i_vrf (
    .clk_i        (clk_i     ),
    .arst_n_i     (arst_n_i  ),
    .rd_a_reg_i   (req_q.vs1 ),
    .rd_b_reg_i   (req_q.vs2 ),
    .rd_slot_i    (slot_q    ),
    .rd_a_data_o  (a_data    ),
    .rd_b_data_o  (b_data    ),
    .wr_en_i      (wr_en     ),
    .wr_reg_i     (req_q.vd  ),
    .wr_slot_i    (slot_q    ),
    .wr_data_i    (alu_res   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  // Global index of the element in this slot
  assign elem_idx = vec_pkg::elem_t'(slot_q) * vec_pkg::elem_t'(NrLanes)
                  + vec_pkg::elem_t'(LaneId);

  always_comb begin
    case (req_q.op)
      vec_pkg::VADD:    alu_res = b_data + a_data;
      vec_pkg::VSUB:    alu_res = b_data - a_data;  // vs2 - vs1
      vec_pkg::VAND:    alu_res = b_data & a_data;
      vec_pkg::VOR:     alu_res = b_data | a_data;
      vec_pkg::VXOR:    alu_res = b_data ^ a_data;
      vec_pkg::VMV_V_X: alu_res = req_q.scalar;
      vec_pkg::VID:     alu_res = elem_idx;
      default:          alu_res = '0;
    endcase
  end

  // Scalar-result ops leave the register file alone
  assign wr_en = busy_q && !(req_q.op inside {vec_pkg::VMV_X_S, vec_pkg::VREDSUM});

  assign lane_resp_o.done    = done_q;
  assign lane_resp_o.partial = partial_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      slot_q <= '0;
    end else begin
      done_q <= busy_q && (slot_q == LastSlot);
      if (pe_req_valid_i) begin
        busy_q <= 1'b1;
        slot_q <= '0;
      end else if (busy_q) begin
        if (slot_q == LastSlot) begin
          busy_q <= 1'b0;
          slot_q <= '0;
        end else begin
          slot_q <= slot_q + 1'b1;
        end
      end
    end
  end

  // Instruction copy and partial scalar
  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      req_q     <= pe_req_i;
      partial_q <= '0;
    end else if (busy_q) begin
      if (req_q.op == vec_pkg::VREDSUM) begin
        partial_q <= partial_q + b_data;
      end else if (req_q.op == vec_pkg::VMV_X_S && slot_q == '0) begin
        partial_q <= b_data;
      end
    end
  end

endmodule

//--- vec_sequencer.sv
/* Broadcasts one instruction to all lanes, waits for every lane to report
   and folds the lane partials into the scalar result. */
`timescale 1ns/1ns

module vec_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // Dispatcher
  input  vec_pkg::vec_pe_req_t                   seq_req_i,
  input  logic                                   seq_req_valid_i,
  output vec_pkg::elem_t                         seq_result_o,
  output logic                                   seq_done_o,
  // Lanes
  output vec_pkg::vec_pe_req_t                   pe_req_o,
  output logic                                   pe_req_valid_o,
  input  vec_pkg::vec_lane_resp_t [NrLanes-1:0]  lane_resp_i
);

  vec_pkg::vec_pe_req_t          pe_req_q;
  logic                          pe_req_valid_q;
  logic           [NrLanes-1:0]  done_q;
  logic                          all_done;
  vec_pkg::elem_t [NrLanes-1:0]  partial_q;
  vec_pkg::elem_t                partial_sum;

  assign pe_req_o       = pe_req_q;
  assign pe_req_valid_o = pe_req_valid_q;

  // Lanes may finish in any order
  assign all_done   = &done_q;
  assign seq_done_o = all_done;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pe_req_valid_q <= 1'b0;
      done_q         <= '0;
    end else begin
      pe_req_valid_q <= seq_req_valid_i;
      if (all_done) begin
        done_q <= '0;
      end else begin
        for (int l = 0; l < NrLanes; l++) begin
          if (lane_resp_i[l].done) begin
            done_q[l] <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (seq_req_valid_i) begin
      pe_req_q <= seq_req_i;
    end
    for (int l = 0; l < NrLanes; l++) begin
      if (lane_resp_i[l].done) begin
        partial_q[l] <= lane_resp_i[l].partial;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scalar result
  ////////////////////////////////////////////////////////////////////////////

  // Wraps modulo 2^32
  always_comb begin
    partial_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      partial_sum = partial_sum + partial_q[l];
    end
  end

  // Element 0 always sits in lane 0
  always_comb begin
    case (pe_req_q.op)
      vec_pkg::VREDSUM: seq_result_o = partial_sum;
      vec_pkg::VMV_X_S: seq_result_o = partial_q[0];
      default:          seq_result_o = '0;
    endcase
  end

endmodule

//--- vec_dispatcher.sv
/* Core-facing front end of the vector unit. Takes one request at a time, answers illegal
   opcodes itself and hands legal ones to the sequencer, then holds the response. */
`timescale 1ns/1ns

module vec_dispatcher (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Scalar core port
  input  vec_pkg::vec_acc_req_t  acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  output vec_pkg::vec_acc_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i,
  // Sequencer
  output vec_pkg::vec_pe_req_t   seq_req_o,
  output logic                   seq_req_valid_o,
  input  vec_pkg::elem_t         seq_result_i,
  input  logic                   seq_done_i
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    RESP
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  logic                   accept;
  logic                   legal;
  logic                   seq_req_valid_q;
  vec_pkg::vec_pe_req_t   seq_req_q;
  vec_pkg::vec_acc_resp_t resp_q;

  // Ready only with nothing in flight and no response pending
  assign acc_req_ready_o  = (state_q == IDLE);
  assign accept           = acc_req_valid_i & acc_req_ready_o;
  assign legal            = (acc_req_i.op <= vec_pkg::VREDSUM);

  assign acc_resp_valid_o = (state_q == RESP);
  assign acc_resp_o       = resp_q;
  assign seq_req_o        = seq_req_q;
  assign seq_req_valid_o  = seq_req_valid_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Illegal opcodes skip the lanes and answer on the next cycle
        if (accept) begin
          state_d = legal ? BUSY : RESP;
        end
      end
      BUSY: begin
        if (seq_done_i) begin
          state_d = RESP;
        end
      end
      RESP: begin
        if (acc_resp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q         <= IDLE;
      seq_req_valid_q <= 1'b0;
    end else begin
      state_q         <= state_d;
      seq_req_valid_q <= accept & legal;
    end
  end

  // Forwarded instruction and the response held for the core
  always_ff @(posedge clk_i) begin
    if (accept) begin
      seq_req_q.op     <= acc_req_i.op;
      seq_req_q.vd     <= acc_req_i.vd;
      seq_req_q.vs1    <= acc_req_i.vs1;
      seq_req_q.vs2    <= acc_req_i.vs2;
      seq_req_q.scalar <= acc_req_i.scalar;
      resp_q.result    <= '0;
      resp_q.error     <= ~legal;
    end else if (state_q == BUSY && seq_done_i) begin
      resp_q.result <= seq_result_i;
      resp_q.error  <= 1'b0;
    end
  end

endmodule

//--- vec_unit.sv
/* Top level of the lane-parallel vector coprocessor. Connects the dispatcher,
   the sequencer and NrLanes lanes; the scalar core sees only the acc port. */
`timescale 1ns/1ns

module vec_unit #(
  parameter int unsigned NrLanes      = 4,  // power of two
  parameter int unsigned ElemsPerLane = 2
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Scalar core port
  input  vec_pkg::vec_acc_req_t  acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  output vec_pkg::vec_acc_resp_t acc_resp_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i
);

  vec_pkg::vec_pe_req_t                   seq_req;
  logic                                   seq_req_valid;
  vec_pkg::elem_t                         seq_result;
  logic                                   seq_done;
  vec_pkg::vec_pe_req_t                   pe_req;
  logic                                   pe_req_valid;
  vec_pkg::vec_lane_resp_t [NrLanes-1:0]  lane_resp;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher and sequencer
  ////////////////////////////////////////////////////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .arst_n_i         (arst_n_i        ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .seq_req_o        (seq_req         ),
    .seq_req_valid_o  (seq_req_valid   ),
    .seq_result_i     (seq_result      ),
    .seq_done_i       (seq_done        )
  );

  vec_sequencer #(
    .NrLanes (NrLanes)
  ) i_sequencer (
    .clk_i           (clk_i        ),
    .arst_n_i        (arst_n_i     ),
    .seq_req_i       (seq_req      ),
    .seq_req_valid_i (seq_req_valid),
    .seq_result_o    (seq_result   ),
    .seq_done_o      (seq_done     ),
    .pe_req_o        (pe_req       ),
    .pe_req_valid_o  (pe_req_valid ),
    .lane_resp_i     (lane_resp    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes      (NrLanes     ),
      .ElemsPerLane (ElemsPerLane),
      .LaneId       (l           )
    ) i_lane (
      .clk_i          (clk_i       ),
      .arst_n_i       (arst_n_i    ),
      .pe_req_i       (pe_req      ),
      .pe_req_valid_i (pe_req_valid),
      .lane_resp_o    (lane_resp[l])
    );
  end

endmodule

//--- tb_vec_unit.sv
/* Self-checking testbench of the vector unit. Builds a table of requests, fills in the
   expected responses from a model of the vector registers and applies the table in a loop. */
`timescale 1ns/1ns

module tb_vec_unit;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemsPerLane = 2;
  localparam int unsigned NrElems      = NrLanes * ElemsPerLane;
  localparam logic [31:0] Seed         = 32'h98ae7dcf;

  typedef struct {
    vec_pkg::vec_acc_req_t req;
    int unsigned           hold;     // cycles with the response held back
    logic                  exp_err;
    vec_pkg::elem_t        exp_res;
  } row_t;

  logic                   clk = 1'b0;
  logic                   arst_n;
  vec_pkg::vec_acc_req_t  acc_req;
  logic                   acc_req_valid;
  logic                   acc_req_ready;
  vec_pkg::vec_acc_resp_t acc_resp;
  logic                   acc_resp_valid;
  logic                   acc_resp_ready;

  row_t           rows [$];
  logic           table_ready = 1'b0;
  logic [31:0]    rnd_state;
  vec_pkg::elem_t vreg_model [vec_pkg::NrVRegs][NrElems];

  vec_unit #(
    .NrLanes      (NrLanes     ),
    .ElemsPerLane (ElemsPerLane)
  ) DUT (
    .clk_i            (clk           ),
    .arst_n_i         (arst_n        ),
    .acc_req_i        (acc_req       ),
    .acc_req_valid_i  (acc_req_valid ),
    .acc_req_ready_o  (acc_req_ready ),
    .acc_resp_o       (acc_resp      ),
    .acc_resp_valid_o (acc_resp_valid),
    .acc_resp_ready_i (acc_resp_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Every row carries a fresh scalar, which only splats use
  task automatic add_row(input vec_pkg::vec_op_e op, input int vd, input int vs1,
                         input int vs2, input int unsigned hold);
    row_t row;
    rnd_state      = lcg_next(rnd_state);
    row.req.op     = op;
    row.req.vd     = vec_pkg::vreg_idx_t'(vd);
    row.req.vs1    = vec_pkg::vreg_idx_t'(vs1);
    row.req.vs2    = vec_pkg::vreg_idx_t'(vs2);
    row.req.scalar = rnd_state;
    row.hold       = hold;
    row.exp_err    = 1'b0;
    row.exp_res    = '0;
    rows.push_back(row);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_step(input vec_pkg::vec_acc_req_t req, output logic err,
                            output vec_pkg::elem_t res);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    err = 1'b0;
    res = '0;
    for (int e = 0; e < NrElems; e++) begin
      a = vreg_model[req.vs1][e];
      b = vreg_model[req.vs2][e];
      case (req.op)
        vec_pkg::VADD:    vreg_model[req.vd][e] = b + a;
        vec_pkg::VSUB:    vreg_model[req.vd][e] = b - a;
        vec_pkg::VAND:    vreg_model[req.vd][e] = b & a;
        vec_pkg::VOR:     vreg_model[req.vd][e] = b | a;
        vec_pkg::VXOR:    vreg_model[req.vd][e] = b ^ a;
        vec_pkg::VMV_V_X: vreg_model[req.vd][e] = req.scalar;
        vec_pkg::VID:     vreg_model[req.vd][e] = vec_pkg::elem_t'(e);
        vec_pkg::VMV_X_S: res = (e == 0) ? b : res;
        vec_pkg::VREDSUM: res = res + b;
        default:          err = 1'b1;
      endcase
    end
  endtask

  task automatic build_table();
    logic           err;
    vec_pkg::elem_t res;
    rnd_state = Seed;
    // Splat, move back, and a register never written
    add_row(vec_pkg::VMV_V_X, 1, 0, 0, 0);
    add_row(vec_pkg::VMV_X_S, 0, 0, 1, 2);
    add_row(vec_pkg::VMV_X_S, 0, 0, 7, 0);
    add_row(vec_pkg::VREDSUM, 0, 0, 7, 0);
    // Index sum 0 .. N-1
    add_row(vec_pkg::VID,     2, 0, 0, 0);
    add_row(vec_pkg::VREDSUM, 0, 0, 2, 3);
    add_row(vec_pkg::VMV_V_X, 3, 0, 0, 0);
    for (int op = 0; op <= 4; op++) begin
      add_row(vec_pkg::vec_op_e'(4'(op)), 4, 3, 2, 0);
      add_row(vec_pkg::VREDSUM, 0, 0, 4, (op == 2) ? 1 : 0);
      add_row(vec_pkg::VMV_X_S, 0, 0, 4, 0);
    end
    // Reversed subtract, then an in-place xor
    add_row(vec_pkg::VSUB,    5, 2, 3, 0);
    add_row(vec_pkg::VREDSUM, 0, 0, 5, 0);
    add_row(vec_pkg::VXOR,    1, 1, 2, 0);
    add_row(vec_pkg::VREDSUM, 0, 0, 1, 0);
    // Illegal codes must leave v2 and v1 untouched
    add_row(vec_pkg::vec_op_e'(4'd9),  2, 3, 4, 2);
    add_row(vec_pkg::vec_op_e'(4'd15), 1, 2, 2, 0);
    add_row(vec_pkg::VREDSUM, 0, 0, 2, 0);
    add_row(vec_pkg::VREDSUM, 0, 0, 1, 1);
    for (int i = 0; i < rows.size(); i++) begin
      model_step(rows[i].req, err, res);
      rows[i].exp_err = err;
      rows[i].exp_res = res;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t row);
    check("acc_req_ready_o before request", 32'(acc_req_ready), 32'd1);
    acc_req        = row.req;
    acc_req_valid  = 1'b1;
    acc_resp_ready = (row.hold == 0);
    @(posedge clk);
    #1;
    acc_req_valid = 1'b0;
    // Illegal opcodes answer on the cycle after acceptance
    if (row.exp_err) begin
      check("acc_resp_valid_o after illegal request", 32'(acc_resp_valid), 32'd1);
    end
    while (!acc_resp_valid) begin
      check("acc_req_ready_o in flight", 32'(acc_req_ready), 32'd0);
      @(posedge clk);
      #1;
    end
    check("acc_resp_o.error", 32'(acc_resp.error), 32'(row.exp_err));
    check("acc_resp_o.result", acc_resp.result, row.exp_res);
    // Response must hold still while the core is not ready
    repeat (row.hold) begin
      @(posedge clk);
      #1;
      check("acc_resp_valid_o under back-pressure", 32'(acc_resp_valid), 32'd1);
      check("held acc_resp_o.result", acc_resp.result, row.exp_res);
      check("held acc_resp_o.error", 32'(acc_resp.error), 32'(row.exp_err));
      check("acc_req_ready_o under back-pressure", 32'(acc_req_ready), 32'd0);
    end
    acc_resp_ready = 1'b1;
    @(posedge clk);
    #1;
    check("acc_resp_valid_o after transfer", 32'(acc_resp_valid), 32'd0);
  endtask

  initial begin
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    arst_n         = 1'b0;
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      for (int e = 0; e < NrElems; e++) begin
        vreg_model[r][e] = '0;
      end
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check("acc_resp_valid_o after reset", 32'(acc_resp_valid), 32'd0);
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i]);
    end
    $display("All checks passed");
    $finish;
  end

  // Upper bound from the table length
  initial begin
    wait (table_ready);
    repeat (rows.size() * (ElemsPerLane + 20) + 10) @(posedge clk);
    $display("Timeout: the vector unit did not answer all %0d requests in time", rows.size());
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- vec_unit.f
vec_pkg.sv
vec_lane_vrf.sv
vec_lane.sv
vec_sequencer.sv
vec_dispatcher.sv
vec_unit.sv
tb_vec_unit.sv

//--- Makefile
# Verilator build and run of the vector unit testbench
TOP       ?= tb_vec_unit
FILELIST  ?= vec_unit.f
VERILATOR ?= verilator
LOG       ?= sim.log
OBJDIR    ?= obj_dir
PASS_MSG  ?= All checks passed

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# The log decides pass or fail
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
